// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_patch_sysex
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+.
synth_patch_pkg.sv
sysex_parser.sv
patch_dump_counter.sv
patch_param_bank.sv
sysex_dump_tx.sv
patch_sysex_top.sv
tb_patch_sysex.sv

// ==== patch_dump_counter.sv ====
`include "synth_patch_defs.svh"

module patch_dump_counter (
    input  logic                          read,
    input  logic                          reset_data_N,
    input  logic                          dump_start,
    output logic                          dump_busy,
    output logic [$clog2(`DUMP_LEN)-1:0]  dump_idx,
    output logic                          tx_tick
);
    localparam int IDX_W = $clog2(`DUMP_LEN);
    localparam int GAP_W = $clog2(`TX_GAP);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`DUMP_LEN - 1);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`TX_GAP - 1);

    logic [GAP_W-1:0] gap_cnt;
    logic             last_sent;                // Final byte ticked, drop busy next

    assign tx_tick = dump_busy && (gap_cnt == GAP_LAST);

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            dump_busy <= 1'b0;
            dump_idx  <= '0;
            gap_cnt   <= '0;
            last_sent <= 1'b0;
        end else if (!dump_busy) begin
            if (dump_start) begin
                dump_busy <= 1'b1;
                dump_idx  <= '0;
                gap_cnt   <= '0;
            end
        end else if (last_sent) begin
            dump_busy <= 1'b0;
            last_sent <= 1'b0;
        end else begin
            gap_cnt <= tx_tick ? '0 : gap_cnt + 1'b1;
            if (tx_tick) begin
                if (dump_idx == IDX_LAST)
                    last_sent <= 1'b1;
                else
                    dump_idx <= dump_idx + 1'b1;
            end
        end
    end

    a_idx_range: assert property (@(posedge read) disable iff (!reset_data_N)
        dump_busy |-> dump_idx <= IDX_LAST);

endmodule

// ==== patch_param_bank.sv ====
`include "synth_patch_defs.svh"

module patch_param_bank (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  logic                        wr_en,
    input  synth_patch_pkg::block_t     wr_block,
    input  synth_patch_pkg::adr_t       wr_adr,
    input  synth_patch_pkg::param_t     wr_data,
    input  synth_patch_pkg::block_t     rd_block,
    input  synth_patch_pkg::adr_t       rd_adr,
    output synth_patch_pkg::param_t     rd_data,
    output synth_patch_pkg::param_t     osc_lvl      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_mod      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_feedb    [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_pan      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_mod_in   [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_feedb_in [`V_OSC-1:0],
    output synth_patch_pkg::param_t     m_vol,
    output synth_patch_pkg::midi_byte_t patch_name   [15:0],
    output synth_patch_pkg::param_t     mod_matrix_a [15:0][`V_OSC-1:0],
    output synth_patch_pkg::param_t     mod_matrix_b [15:0][`V_OSC-1:0]
);
    import synth_patch_pkg::*;

    logic [2:0] wr_osc;                         // Upper address bits pick the osc
    logic [3:0] wr_sub;                         // Param offset or matrix row
    logic [2:0] rd_osc;
    logic [3:0] rd_sub;
    param_t     rd_val;

    assign wr_osc = wr_adr[6:4];
    assign wr_sub = wr_adr[3:0];
    assign rd_osc = rd_adr[6:4];
    assign rd_sub = rd_adr[3:0];

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            for (int o = 0; o < `V_OSC; o++) begin
                osc_lvl[o]      <= (o < 2) ? `DEF_LEVEL : 8'h00;
                osc_mod[o]      <= '0;
                osc_feedb[o]    <= '0;
                osc_pan[o]      <= `DEF_PAN;
                osc_mod_in[o]   <= '0;
                osc_feedb_in[o] <= '0;
            end
            for (int r = 0; r < 16; r++) begin
                patch_name[r] <= `DEF_NAME_CHAR;
                for (int o = 0; o < `V_OSC; o++) begin
                    mod_matrix_a[r][o] <= '0;
                    mod_matrix_b[r][o] <= '0;
                end
            end
            m_vol <= `DEF_VOLUME;
        end else if (wr_en) begin
            case (wr_block)
                BLK_OSC: begin
                    for (int o = 0; o < `V_OSC; o++) begin
                        if (wr_osc == 3'(o)) begin
                            case (wr_sub)
                                4'd2:    osc_lvl[o]      <= wr_data;
                                4'd3:    osc_mod[o]      <= wr_data;
                                4'd4:    osc_feedb[o]    <= wr_data;
                                4'd7:    osc_pan[o]      <= wr_data;
                                4'd10:   osc_mod_in[o]   <= wr_data;
                                4'd11:   osc_feedb_in[o] <= wr_data;
                                default: ;
                            endcase
                        end
                    end
                end
                BLK_COMMON: begin
                    if (wr_adr == 7'd1)
                        m_vol <= wr_data;
                    else if (wr_osc == 3'd1)
                        patch_name[wr_sub] <= wr_data;    // Name at 16..31
                end
                BLK_MAT1: begin
                    for (int o = 0; o < `V_OSC; o++) begin
                        if (wr_osc == 3'(o))
                            mod_matrix_a[wr_sub][o] <= wr_data;
                    end
                end
                BLK_MAT2: begin
                    for (int o = 0; o < `V_OSC; o++) begin
                        if (wr_osc == 3'(o))
                            mod_matrix_b[wr_sub][o] <= wr_data;
                    end
                end
                default: ;
            endcase
        end
    end

    // Same map for reading, holes give zero
    always_comb begin
        rd_val = '0;
        case (rd_block)
            BLK_OSC: begin
                for (int o = 0; o < `V_OSC; o++) begin
                    if (rd_osc == 3'(o)) begin
                        case (rd_sub)
                            4'd2:    rd_val = osc_lvl[o];
                            4'd3:    rd_val = osc_mod[o];
                            4'd4:    rd_val = osc_feedb[o];
                            4'd7:    rd_val = osc_pan[o];
                            4'd10:   rd_val = osc_mod_in[o];
                            4'd11:   rd_val = osc_feedb_in[o];
                            default: ;
                        endcase
                    end
                end
            end
            BLK_COMMON: begin
                if (rd_adr == 7'd1)
                    rd_val = m_vol;
                else if (rd_osc == 3'd1)
                    rd_val = param_t'(patch_name[rd_sub]);
            end
            BLK_MAT1: begin
                for (int o = 0; o < `V_OSC; o++) begin
                    if (rd_osc == 3'(o))
                        rd_val = mod_matrix_a[rd_sub][o];
                end
            end
            BLK_MAT2: begin
                for (int o = 0; o < `V_OSC; o++) begin
                    if (rd_osc == 3'(o))
                        rd_val = mod_matrix_b[rd_sub][o];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge read) begin
        rd_data <= rd_val;
    end

    a_wr_known: assert property (@(posedge read) disable iff (!reset_data_N)
        wr_en |-> !$isunknown({wr_block, wr_adr, wr_data}));

endmodule

// ==== patch_sysex_top.sv ====
`include "synth_patch_defs.svh"

module patch_sysex_top (
    input  logic                        read,
    input  logic                        reset_data_N,
    input  synth_patch_pkg::midi_byte_t midi_byte,
    input  logic                        byte_strobe,
    output synth_patch_pkg::midi_byte_t tx_byte,
    output logic                        tx_strobe,
    output logic                        dump_busy,
    output synth_patch_pkg::param_t     osc_lvl      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_mod      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_feedb    [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_pan      [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_mod_in   [`V_OSC-1:0],
    output synth_patch_pkg::param_t     osc_feedb_in [`V_OSC-1:0],
    output synth_patch_pkg::param_t     m_vol,
    output synth_patch_pkg::midi_byte_t patch_name   [15:0],
    output synth_patch_pkg::param_t     mod_matrix_a [15:0][`V_OSC-1:0],
    output synth_patch_pkg::param_t     mod_matrix_b [15:0][`V_OSC-1:0]
);
    import synth_patch_pkg::*;

    logic                         wr_en;
    block_t                       wr_block;
    adr_t                         wr_adr;
    param_t                       wr_data;
    logic                         dump_start;
    block_t                       dump_block;
    logic [$clog2(`DUMP_LEN)-1:0] dump_idx;
    logic                         tx_tick;
    block_t                       rd_block;
    adr_t                         rd_adr;
    param_t                       rd_data;

    sysex_parser sysex_parser_inst (
        .read, .reset_data_N, .midi_byte, .byte_strobe, .dump_busy,
        .wr_en, .wr_block, .wr_adr, .wr_data, .dump_start, .dump_block
    );

    patch_dump_counter patch_dump_counter_inst (
        .read, .reset_data_N, .dump_start, .dump_busy, .dump_idx, .tx_tick
    );

    patch_param_bank patch_param_bank_inst (
        .read, .reset_data_N, .wr_en, .wr_block, .wr_adr, .wr_data,
        .rd_block, .rd_adr, .rd_data,
        .osc_lvl, .osc_mod, .osc_feedb, .osc_pan, .osc_mod_in, .osc_feedb_in,
        .m_vol, .patch_name, .mod_matrix_a, .mod_matrix_b
    );

    sysex_dump_tx sysex_dump_tx_inst (
        .read, .reset_data_N, .dump_busy, .dump_idx, .tx_tick, .dump_block,
        .rd_data, .rd_block, .rd_adr, .tx_byte, .tx_strobe
    );

endmodule

// ==== synth_patch_defs.svh ====
`ifndef SYNTH_PATCH_DEFS_SVH
`define SYNTH_PATCH_DEFS_SVH

`define V_OSC           4           // Oscillators per voice

// SysEx framing and command bytes
`define SYSEX_START     8'hF0
`define SYSEX_END       8'hF7
`define SYSEX_ID        8'h7D       // Id this synth answers to
`define CMD_WRITE       8'h01
`define CMD_DUMP_REQ    8'h02
`define CMD_DUMP        8'h03

`define TX_GAP          4           // Cycles between dump bytes, at least 2
`define DUMP_LEN        134         // 4 header, 128 data, checksum, end

// Power-on patch
`define DEF_LEVEL       8'h40
`define DEF_PAN         8'h40
`define DEF_VOLUME      8'h40
`define DEF_NAME_CHAR   8'h20       // ASCII space

`endif

// ==== synth_patch_pkg.sv ====
package synth_patch_pkg;

    typedef logic [7:0]        midi_byte_t;     // Raw MIDI byte
    typedef logic [6:0]        adr_t;           // Address inside a block
    typedef logic signed [7:0] param_t;         // One patch parameter

    typedef enum logic [1:0] {
        BLK_OSC    = 2'd0,
        BLK_COMMON = 2'd1,
        BLK_MAT1   = 2'd2,
        BLK_MAT2   = 2'd3
    } block_t;

    typedef enum logic [2:0] {
        ST_IDLE,                                // Waiting for F0
        ST_ID,
        ST_CMD,
        ST_BLOCK,
        ST_ADR,
        ST_DATA,
        ST_END,
        ST_SKIP                                 // Not for us, wait for next F0
    } parser_state_t;

endpackage

// ==== sysex_dump_tx.sv ====
`include "synth_patch_defs.svh"

module sysex_dump_tx (
    input  logic                          read,
    input  logic                          reset_data_N,
    input  logic                          dump_busy,
    input  logic [$clog2(`DUMP_LEN)-1:0]  dump_idx,
    input  logic                          tx_tick,
    input  synth_patch_pkg::block_t       dump_block,
    input  synth_patch_pkg::param_t       rd_data,
    output synth_patch_pkg::block_t       rd_block,
    output synth_patch_pkg::adr_t         rd_adr,
    output synth_patch_pkg::midi_byte_t   tx_byte,
    output logic                          tx_strobe
);
    import synth_patch_pkg::*;

    localparam int IDX_W = $clog2(`DUMP_LEN);
    localparam logic [IDX_W-1:0] IDX_DATA0 = IDX_W'(4);
    localparam logic [IDX_W-1:0] IDX_CHK   = IDX_W'(`DUMP_LEN - 2);
    localparam logic [IDX_W-1:0] IDX_END   = IDX_W'(`DUMP_LEN - 1);

    logic [6:0] sum;                            // Running sum of data bytes, mod 128
    logic       in_data;
    midi_byte_t nxt_byte;

    // Address follows the index, so the bank has the whole gap to answer
    assign rd_block = dump_block;
    assign rd_adr   = adr_t'(dump_idx - IDX_DATA0);
    assign in_data  = (dump_idx >= IDX_DATA0) && (dump_idx < IDX_CHK);

    always_comb begin
        case (dump_idx)
            IDX_W'(0): nxt_byte = `SYSEX_START;
            IDX_W'(1): nxt_byte = `SYSEX_ID;
            IDX_W'(2): nxt_byte = `CMD_DUMP;
            IDX_W'(3): nxt_byte = {6'd0, dump_block};
            IDX_CHK:   nxt_byte = {1'b0, 7'd0 - sum};
            IDX_END:   nxt_byte = `SYSEX_END;
            default:   nxt_byte = {1'b0, rd_data[6:0]};
        endcase
    end

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            tx_strobe <= 1'b0;
            sum       <= '0;
        end else begin
            tx_strobe <= tx_tick;
            if (!dump_busy)
                sum <= '0;
            else if (tx_tick && in_data)
                sum <= sum + rd_data[6:0];
        end
    end

    always_ff @(posedge read) begin
        if (tx_tick)
            tx_byte <= nxt_byte;
    end

    a_strobe_busy: assert property (@(posedge read) disable iff (!reset_data_N)
        tx_strobe |-> dump_busy);

endmodule

// ==== sysex_parser.sv ====
`include "synth_patch_defs.svh"

module sysex_parser (
    input  logic                       read,
    input  logic                       reset_data_N,
    input  synth_patch_pkg::midi_byte_t midi_byte,
    input  logic                       byte_strobe,
    input  logic                       dump_busy,
    output logic                       wr_en,
    output synth_patch_pkg::block_t    wr_block,
    output synth_patch_pkg::adr_t      wr_adr,
    output synth_patch_pkg::param_t    wr_data,
    output logic                       dump_start,
    output synth_patch_pkg::block_t    dump_block
);
    import synth_patch_pkg::*;

    parser_state_t state;
    logic          is_wr;                       // Set for a write message
    logic          stray;

    // Status byte inside a message other than F7 in the end slot
    assign stray = midi_byte[7] && !(state == ST_END && midi_byte == `SYSEX_END);

    always_ff @(posedge read) begin
        if (!reset_data_N) begin
            state      <= ST_IDLE;
            is_wr      <= 1'b0;
            wr_en      <= 1'b0;
            dump_start <= 1'b0;
            dump_block <= BLK_OSC;
        end else begin
            wr_en      <= 1'b0;
            dump_start <= 1'b0;
            if (byte_strobe) begin
                if (midi_byte == `SYSEX_START) begin
                    state <= ST_ID;             // Also restarts a broken message
                end else if (stray) begin
                    state <= ST_IDLE;
                end else begin
                    case (state)
                        ST_ID: begin
                            state <= (midi_byte == `SYSEX_ID) ? ST_CMD : ST_SKIP;
                        end
                        ST_CMD: begin
                            is_wr <= (midi_byte == `CMD_WRITE);
                            if (midi_byte == `CMD_WRITE || midi_byte == `CMD_DUMP_REQ)
                                state <= ST_BLOCK;
                            else
                                state <= ST_SKIP;
                        end
                        ST_BLOCK: begin
                            wr_block <= block_t'(midi_byte[1:0]);
                            if (midi_byte[6:2] != 5'd0)
                                state <= ST_SKIP;   // No such block
                            else
                                state <= is_wr ? ST_ADR : ST_END;
                        end
                        ST_ADR: begin
                            wr_adr <= midi_byte[6:0];
                            state  <= ST_DATA;
                        end
                        ST_DATA: begin
                            wr_data <= {1'b0, midi_byte[6:0]};
                            state   <= ST_END;
                        end
                        ST_END: begin
                            if (midi_byte == `SYSEX_END) begin
                                state <= ST_IDLE;
                                if (is_wr) begin
                                    wr_en <= 1'b1;
                                end else if (!dump_busy) begin
                                    dump_start <= 1'b1;
                                    dump_block <= wr_block;
                                end
                            end else begin
                                state <= ST_SKIP;   // Too many data bytes
                            end
                        end
                        default: ;              // Idle and skip drop data bytes
                    endcase
                end
            end
        end
    end

    a_one_cmd: assert property (@(posedge read) disable iff (!reset_data_N)
        !(wr_en && dump_start));

endmodule

// ==== tb_patch_sysex.sv ====
`include "synth_patch_defs.svh"

module tb_patch_sysex;
    import synth_patch_pkg::*;

    localparam int N_WRITES = 64;
    localparam int N_BAD    = 48;
    localparam int N_MSGS   = N_WRITES + N_BAD + 6;
    localparam int WATCHDOG_CYCLES = 2 * (N_MSGS * 6 * 2 + 5 * `DUMP_LEN * `TX_GAP) + 1000;

    logic       read = 1'b0;
    logic       reset_data_N;
    midi_byte_t midi_byte;
    logic       byte_strobe;
    midi_byte_t tx_byte;
    logic       tx_strobe;
    logic       dump_busy;
    param_t     osc_lvl      [`V_OSC-1:0];
    param_t     osc_mod      [`V_OSC-1:0];
    param_t     osc_feedb    [`V_OSC-1:0];
    param_t     osc_pan      [`V_OSC-1:0];
    param_t     osc_mod_in   [`V_OSC-1:0];
    param_t     osc_feedb_in [`V_OSC-1:0];
    param_t     m_vol;
    midi_byte_t patch_name   [15:0];
    param_t     mod_matrix_a [15:0][`V_OSC-1:0];
    param_t     mod_matrix_b [15:0][`V_OSC-1:0];

    logic [7:0] model    [0:3][0:127];          // Expected bank with zero holes
    logic [7:0] exp_dump [0:`DUMP_LEN-1];
    logic [7:0] rx_bytes [$];
    int         checks;
    int         errors;
    int         test_start;
    int         kind;
    int         n_f0;
    logic [1:0] blk;
    logic [6:0] adr;
    logic [6:0] data;

    patch_sysex_top patch_sysex_top_inst (.*);

    always #2 read = ~read;

    task automatic init_model();
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < 128; a++) begin
                model[b][a] = 8'h00;
            end
        end
        for (int o = 0; o < `V_OSC; o++) begin
            model[0][o*16+2] = (o < 2) ? `DEF_LEVEL : 8'h00;
            model[0][o*16+7] = `DEF_PAN;
        end
        model[1][1] = `DEF_VOLUME;
        for (int r = 0; r < 16; r++) begin
            model[1][16+r] = `DEF_NAME_CHAR;
        end
    endtask

    function automatic logic is_mapped(input logic [1:0] b, input logic [6:0] a);
        logic [2:0] osc;
        logic [3:0] sub;
        osc = a[6:4];
        sub = a[3:0];
        case (b)
            2'd0:    return (int'(osc) < `V_OSC) &&
                            (sub inside {4'd2, 4'd3, 4'd4, 4'd7, 4'd10, 4'd11});
            2'd1:    return (a == 7'd1) || (osc == 3'd1);
            default: return int'(osc) < `V_OSC;
        endcase
    endfunction

    task automatic send_byte(input midi_byte_t b);
        midi_byte   = b;
        byte_strobe = 1'b1;
        @(negedge read);
        byte_strobe = 1'b0;
    endtask

    task automatic send_write_head(input midi_byte_t id, input logic [1:0] b,
                                   input logic [6:0] a);
        send_byte(`SYSEX_START);
        send_byte(id);
        send_byte(`CMD_WRITE);
        send_byte({6'd0, b});
        send_byte({1'b0, a});
    endtask

    task automatic send_write(input logic [1:0] b, input logic [6:0] a, input logic [6:0] d);
        send_write_head(`SYSEX_ID, b, a);
        send_byte({1'b0, d});
        send_byte(`SYSEX_END);                  // Returns one edge after F7
    endtask

    task automatic send_dump_req(input logic [1:0] b);
        send_byte(`SYSEX_START);
        send_byte(`SYSEX_ID);
        send_byte(`CMD_DUMP_REQ);
        send_byte({6'd0, b});
        send_byte(`SYSEX_END);
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_all();
        for (int o = 0; o < `V_OSC; o++) begin
            check_value($sformatf("osc_lvl[%0d]", o), osc_lvl[o], model[0][o*16+2]);
            check_value($sformatf("osc_mod[%0d]", o), osc_mod[o], model[0][o*16+3]);
            check_value($sformatf("osc_feedb[%0d]", o), osc_feedb[o], model[0][o*16+4]);
            check_value($sformatf("osc_pan[%0d]", o), osc_pan[o], model[0][o*16+7]);
            check_value($sformatf("osc_mod_in[%0d]", o), osc_mod_in[o], model[0][o*16+10]);
            check_value($sformatf("osc_feedb_in[%0d]", o), osc_feedb_in[o],
                        model[0][o*16+11]);
        end
        check_value("m_vol", m_vol, model[1][1]);
        for (int r = 0; r < 16; r++) begin
            check_value($sformatf("patch_name[%0d]", r), patch_name[r], model[1][16+r]);
            for (int o = 0; o < `V_OSC; o++) begin
                check_value($sformatf("mod_matrix_a[%0d][%0d]", r, o), mod_matrix_a[r][o],
                            model[2][o*16+r]);
                check_value($sformatf("mod_matrix_b[%0d][%0d]", r, o), mod_matrix_b[r][o],
                            model[3][o*16+r]);
            end
        end
    endtask

    task automatic expect_dump(input logic [1:0] b);
        logic [6:0] sum;
        sum = 7'd0;
        exp_dump[0] = `SYSEX_START;
        exp_dump[1] = `SYSEX_ID;
        exp_dump[2] = `CMD_DUMP;
        exp_dump[3] = {6'd0, b};
        for (int a = 0; a < 128; a++) begin
            exp_dump[4+a] = {1'b0, model[b][a][6:0]};
            sum = sum + model[b][a][6:0];
        end
        exp_dump[`DUMP_LEN-2] = {1'b0, ~sum + 7'd1};   // Low 7 bits of the negated sum
        exp_dump[`DUMP_LEN-1] = `SYSEX_END;
    endtask

    task automatic collect_dump();
        int waited;
        waited = 0;
        rx_bytes.delete();
        while (!dump_busy && waited < 8) begin
            @(negedge read);
            waited++;
        end
        checks++;
        assert (dump_busy) else begin
            $display("Failure at time %0t: dump_busy did not rise after a dump request",
                     $time);
            errors++;
        end
        while (dump_busy) begin
            @(negedge read);
            if (tx_strobe)
                rx_bytes.push_back(tx_byte);
        end
    endtask

    task automatic check_dump(input logic [1:0] b);
        expect_dump(b);
        checks++;
        assert (rx_bytes.size() == `DUMP_LEN) else begin
            $display("Failure at time %0t: dump of block %0d sent %0d bytes instead of %0d",
                     $time, b, rx_bytes.size(), `DUMP_LEN);
            errors++;
        end
        for (int i = 0; i < rx_bytes.size() && i < `DUMP_LEN; i++) begin
            check_value($sformatf("tx_byte[%0d]", i), rx_bytes[i], exp_dump[i]);
        end
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        void'($urandom(32'heab99fda));
        reset_data_N = 1'b0;
        midi_byte    = 8'h00;
        byte_strobe  = 1'b0;
        checks       = 0;
        errors       = 0;
        test_start   = 0;
        init_model();
        repeat (10) @(negedge read);
        reset_data_N = 1'b1;
        @(negedge read);

        check_all();
        check_value("dump_busy", 8'(dump_busy), 8'h00);
        check_value("tx_strobe", 8'(tx_strobe), 8'h00);
        report_test("reset_defaults");

        for (int n = 0; n < N_WRITES; n++) begin
            blk = 2'(n % 4);
            adr = 7'($urandom % 128);
            while (!is_mapped(blk, adr))
                adr = 7'($urandom % 128);
            data = 7'($urandom % 128);
            send_write(blk, adr, data);
            check_all();                        // Bank not written on the wr_en edge
            @(negedge read);
            model[blk][adr] = {1'b0, data};
            check_all();
        end
        report_test("mapped_writes");

        for (int n = 0; n < N_BAD; n++) begin
            blk  = 2'(n % 4);
            kind = int'($urandom % 4);
            adr  = 7'($urandom % 128);
            while (is_mapped(blk, adr) == (kind == 0))  // Unmapped only for kind 0
                adr = 7'($urandom % 128);
            data = model[blk][adr][6:0] ^ 7'(1 + $urandom % 127);  // Differs from the bank
            case (kind)
                0: begin
                    send_write(blk, adr, data);
                end
                1: begin
                    send_write_head({1'b0, 7'($urandom % 125)}, blk, adr);   // Id below 7D
                    send_byte({1'b0, data});
                    send_byte(`SYSEX_END);
                end
                2: begin
                    send_byte(`SYSEX_START);
                    send_byte(`SYSEX_ID);
                    send_byte(`CMD_WRITE);
                    send_byte({6'd0, blk});
                    send_byte({1'b1, adr});     // Status byte in the address slot
                    send_byte({1'b0, data});
                    send_byte(`SYSEX_END);
                end
                default: begin
                    send_write_head(`SYSEX_ID, blk, adr);
                    send_byte({1'b0, data});
                    send_byte({1'b0, data});    // Extra byte where F7 belongs
                    send_byte(`SYSEX_END);
                end
            endcase
            repeat (2) @(negedge read);
            check_all();
        end
        report_test("ignored_messages");

        for (int b = 0; b < 4; b++) begin
            send_dump_req(2'(b));
            collect_dump();
            check_dump(2'(b));
        end
        report_test("block_dumps");

        send_dump_req(2'd1);
        fork
            collect_dump();
            begin
                repeat (40) @(negedge read);
                send_dump_req(2'd2);            // Arrives mid-dump
            end
        join
        check_dump(2'd1);
        n_f0 = 0;
        foreach (rx_bytes[i]) begin
            if (rx_bytes[i] == `SYSEX_START)
                n_f0++;
        end
        check_value("tx_byte F0 count", 8'(n_f0), 8'd1);
        repeat (4 * `TX_GAP) begin
            @(negedge read);
            check_value("dump_busy", 8'(dump_busy), 8'h00);
            check_value("tx_strobe", 8'(tx_strobe), 8'h00);
        end
        report_test("busy_request_dropped");

        $display("Tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge read);
        $display("Timeout: simulation did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule
